// ==== Bender.yml ====
package:
  name: dual_core

export_include_dirs:
  - common

sources:
  - common/dual_core_pkg.sv
  - exec_lane/alu.sv
  - exec_lane/exec_lane.sv
  - rtl/issue_steer.sv
  - rtl/reg_file.sv
  - rtl/dual_core.sv
  - target: test
    include_dirs:
      - testbench
    files:
      - testbench/tb_dual_core.sv

// ==== common/dual_core_cfg.svh ====
`ifndef DUAL_CORE_CFG_SVH
`define DUAL_CORE_CFG_SVH

// datapath width of every operand and result
`define DC_DATA_WIDTH 32

// architectural register file
`define DC_NUM_REGS 32
`define DC_REG_ADDR_BITS 5

// instruction field widths
`define DC_OPCODE_BITS 6
`define DC_SHAMT_BITS 5

// immediate covers rd, shamt and the spare low bits
`define DC_IMM_BITS 16

`endif

// ==== common/dual_core_pkg.sv ====
`default_nettype none

`include "dual_core_cfg.svh"

package dual_core_pkg;

  // nop must stay at zero so an all-zero word is harmless
  typedef enum logic [`DC_OPCODE_BITS-1:0] {
    OP_NOP  = 0,
    OP_ADD  = 1,
    OP_SUB  = 2,
    OP_AND  = 3,
    OP_OR   = 4,
    OP_XOR  = 5,
    OP_SLT  = 6,
    OP_SLL  = 7,
    OP_ADDI = 8
  } opcode_e;

  // low half of an R-type word
  typedef struct packed {
    logic [`DC_REG_ADDR_BITS-1:0]                                  rd;
    logic [`DC_SHAMT_BITS-1:0]                                     shamt;
    logic [`DC_IMM_BITS-`DC_REG_ADDR_BITS-`DC_SHAMT_BITS-1:0]      funct;
  } rfmt_t;

  // immediate lies over rd and shamt
  typedef union packed {
    rfmt_t                   r;
    logic [`DC_IMM_BITS-1:0] imm;
  } inst_low_t;

  typedef struct packed {
    opcode_e                      opcode;
    logic [`DC_REG_ADDR_BITS-1:0] rs;
    logic [`DC_REG_ADDR_BITS-1:0] rt;
    inst_low_t                    f;
  } inst_t;

  typedef struct packed {
    inst_t older;
    inst_t younger;
  } inst_pair_t;

  typedef struct packed {
    logic  valid;
    inst_t inst;
  } slot_t;

  typedef struct packed {
    logic [`DC_DATA_WIDTH-1:0] rs_val;
    logic [`DC_DATA_WIDTH-1:0] rt_val;
  } operands_t;

  typedef struct packed {
    logic                         valid;
    logic [`DC_REG_ADDR_BITS-1:0] dest;
    logic [`DC_DATA_WIDTH-1:0]    value;
  } retire_t;

  typedef struct packed {
    logic                         wr;
    logic [`DC_REG_ADDR_BITS-1:0] idx;
  } dest_t;

  // r-type writes rd, addi writes rt, r0 never counts as a write
  function automatic dest_t dest_of(slot_t s);
    dest_t d;
    case (s.inst.opcode)
      OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_SLT, OP_SLL: d.idx = s.inst.f.r.rd;
      OP_ADDI: d.idx = s.inst.rt;
      default: d.idx = '0;
    endcase
    d.wr = s.valid && (d.idx != '0);
    return d;
  endfunction

endpackage

`default_nettype wire

// ==== exec_lane/alu.sv ====
`default_nettype none

`include "dual_core_cfg.svh"

module alu (
  input  dual_core_pkg::opcode_e    op,
  input  logic [`DC_DATA_WIDTH-1:0] a,
  input  logic [`DC_DATA_WIDTH-1:0] b,
  input  logic [`DC_SHAMT_BITS-1:0] shamt,
  output logic [`DC_DATA_WIDTH-1:0] result
);

  always_comb begin
    case (op)
      dual_core_pkg::OP_ADD,
      dual_core_pkg::OP_ADDI: result = a + b;
      dual_core_pkg::OP_SUB:  result = a - b;
      dual_core_pkg::OP_AND:  result = a & b;
      dual_core_pkg::OP_OR:   result = a | b;
      dual_core_pkg::OP_XOR:  result = a ^ b;
      // signed compare
      dual_core_pkg::OP_SLT:  result = {{(`DC_DATA_WIDTH-1){1'b0}}, $signed(a) < $signed(b)};
      // shifts rt by the instruction's shamt
      dual_core_pkg::OP_SLL:  result = b << shamt;
      default:                result = '0;
    endcase
  end

  // lane decode maps anything outside the set to nop
  always_comb begin
    if (!$isunknown(op)) begin
      a_known_op: assert final (op inside {dual_core_pkg::OP_NOP, dual_core_pkg::OP_ADD,
                                           dual_core_pkg::OP_SUB, dual_core_pkg::OP_AND,
                                           dual_core_pkg::OP_OR, dual_core_pkg::OP_XOR,
                                           dual_core_pkg::OP_SLT, dual_core_pkg::OP_SLL,
                                           dual_core_pkg::OP_ADDI})
        else $error("alu: opcode %0h outside the decoded set", op);
    end
  end

endmodule

`default_nettype wire

// ==== exec_lane/exec_lane.sv ====
`default_nettype none

`include "dual_core_cfg.svh"

module exec_lane (
  input  logic                     clk,
  input  logic                     rst_n,
  input  dual_core_pkg::slot_t     slot,
  input  dual_core_pkg::operands_t operands,
  input  dual_core_pkg::retire_t   fwd0,
  input  dual_core_pkg::retire_t   fwd1,
  output dual_core_pkg::retire_t   retire
);

  logic                         idex_valid;
  dual_core_pkg::inst_t         idex_inst;
  dual_core_pkg::operands_t     idex_ops;
  dual_core_pkg::slot_t         idex_slot;
  dual_core_pkg::dest_t         ex_dest;
  dual_core_pkg::opcode_e       alu_op;
  logic [`DC_DATA_WIDTH-1:0]    op_a;
  logic [`DC_DATA_WIDTH-1:0]    rt_val;
  logic [`DC_DATA_WIDTH-1:0]    op_b;
  logic [`DC_DATA_WIDTH-1:0]    alu_result;
  logic                         wb_valid;
  logic [`DC_REG_ADDR_BITS-1:0] wb_dest;
  logic [`DC_DATA_WIDTH-1:0]    wb_value;

  // lane1 holds the younger instruction and wins a tie
  function automatic logic [`DC_DATA_WIDTH-1:0] pick_operand(
    input logic [`DC_REG_ADDR_BITS-1:0] src,
    input logic [`DC_DATA_WIDTH-1:0]    file_val,
    input dual_core_pkg::retire_t       f0,
    input dual_core_pkg::retire_t       f1
  );
    if (f1.valid && (f1.dest == src)) begin
      return f1.value;
    end else if (f0.valid && (f0.dest == src)) begin
      return f0.value;
    end
    return file_val;
  endfunction

  ////////////////////
  // id/ex register

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      idex_valid <= 1'b0;
    end else begin
      idex_valid <= slot.valid;
    end
  end

  always_ff @(posedge clk) begin
    idex_inst <= slot.inst;
    idex_ops  <= operands;
  end

  ////////////////////
  // execute

  assign idex_slot = '{valid: idex_valid, inst: idex_inst};
  assign ex_dest   = dual_core_pkg::dest_of(idex_slot);

  assign op_a   = pick_operand(idex_inst.rs, idex_ops.rs_val, fwd0, fwd1);
  assign rt_val = pick_operand(idex_inst.rt, idex_ops.rt_val, fwd0, fwd1);

  // addi takes the zero-extended immediate in place of rt
  assign op_b = (idex_inst.opcode == dual_core_pkg::OP_ADDI) ?
                {{(`DC_DATA_WIDTH-`DC_IMM_BITS){1'b0}}, idex_inst.f.imm} : rt_val;

  // unknown opcodes and empty slots reach the alu as nop
  assign alu_op = ex_dest.wr ? idex_inst.opcode : dual_core_pkg::OP_NOP;

  alu u_alu (
    .op     (alu_op),
    .a      (op_a),
    .b      (op_b),
    .shamt  (idex_inst.f.r.shamt),
    .result (alu_result)
  );

  ////////////////////
  // ex/wb register

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wb_valid <= 1'b0;
    end else begin
      wb_valid <= ex_dest.wr;
    end
  end

  always_ff @(posedge clk) begin
    wb_dest  <= ex_dest.idx;
    wb_value <= alu_result;
  end

  assign retire = '{valid: wb_valid, dest: wb_dest, value: wb_value};

  // a forward to r0 would override reads of the zero register
  a_fwd_dest: assert property (
    @(posedge clk) disable iff (!rst_n)
    !(fwd0.valid && (fwd0.dest == '0)) && !(fwd1.valid && (fwd1.dest == '0))
  ) else $error("exec_lane: forwarded result targets register zero");

endmodule

`default_nettype wire

// ==== flist.f ====
+incdir+common
+incdir+testbench
common/dual_core_pkg.sv
exec_lane/alu.sv
exec_lane/exec_lane.sv
rtl/issue_steer.sv
rtl/reg_file.sv
rtl/dual_core.sv
testbench/tb_dual_core.sv

// ==== rtl/dual_core.sv ====
`default_nettype none

module dual_core (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      in_valid,
  output logic                      in_ready,
  input  dual_core_pkg::inst_pair_t in_pair,
  output dual_core_pkg::retire_t    retire0,
  output dual_core_pkg::retire_t    retire1
);

  // steer to register file and lanes
  dual_core_pkg::slot_t     slot0;
  dual_core_pkg::slot_t     slot1;

  // register file to lanes
  dual_core_pkg::operands_t operands0;
  dual_core_pkg::operands_t operands1;

  ////////////////////
  // issue

  issue_steer u_steer (
    .clk      (clk),
    .rst_n    (rst_n),
    .in_valid (in_valid),
    .in_ready (in_ready),
    .in_pair  (in_pair),
    .slot0    (slot0),
    .slot1    (slot1)
  );

  reg_file u_rf (
    .clk       (clk),
    .rst_n     (rst_n),
    .slot0     (slot0),
    .slot1     (slot1),
    .retire0   (retire0),
    .retire1   (retire1),
    .operands0 (operands0),
    .operands1 (operands1)
  );

  ////////////////////
  // lanes, each sees both results for forwarding

  exec_lane u_lane0 (
    .clk      (clk),
    .rst_n    (rst_n),
    .slot     (slot0),
    .operands (operands0),
    .fwd0     (retire0),
    .fwd1     (retire1),
    .retire   (retire0)
  );

  exec_lane u_lane1 (
    .clk      (clk),
    .rst_n    (rst_n),
    .slot     (slot1),
    .operands (operands1),
    .fwd0     (retire0),
    .fwd1     (retire1),
    .retire   (retire1)
  );

endmodule

`default_nettype wire

// ==== rtl/issue_steer.sv ====
`default_nettype none

module issue_steer (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      in_valid,
  output logic                      in_ready,
  input  dual_core_pkg::inst_pair_t in_pair,
  output dual_core_pkg::slot_t      slot0,
  output dual_core_pkg::slot_t      slot1
);

  logic                      valid_q;
  logic                      second_q;
  dual_core_pkg::inst_pair_t pair_q;
  dual_core_pkg::slot_t      older_slot;
  dual_core_pkg::dest_t      older_dest;
  logic                      dep;
  logic                      split;

  ////////////////////
  // pair register

  // second_q marks the cycle that issues the held-back younger instruction
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      valid_q  <= 1'b0;
      second_q <= 1'b0;
    end else begin
      second_q <= split;
      if (!split) begin
        valid_q <= in_valid;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (in_valid && in_ready) begin
      pair_q <= in_pair;
    end
  end

  ////////////////////
  // dependency check

  assign older_slot = '{valid: valid_q, inst: pair_q.older};
  assign older_dest = dual_core_pkg::dest_of(older_slot);

  // younger reads what older writes
  assign dep = older_dest.wr &&
               ((pair_q.younger.rs == older_dest.idx) ||
                (pair_q.younger.rt == older_dest.idx));

  assign split    = valid_q && !second_q && dep;
  assign in_ready = !split;

  ////////////////////
  // slot outputs

  assign slot0 = '{valid: valid_q && !second_q, inst: pair_q.older};
  assign slot1 = '{valid: valid_q && (second_q || !dep), inst: pair_q.younger};

  // an offered pair stays on the stream unchanged while in_ready is low
  a_hold_pair: assert property (
    @(posedge clk) disable iff (!rst_n)
    (in_valid && !in_ready) |=> (in_valid && $stable(in_pair))
  ) else $error("issue_steer: pair withdrawn or changed while in_ready was low");

endmodule

`default_nettype wire

// ==== rtl/reg_file.sv ====
`default_nettype none

`include "dual_core_cfg.svh"

module reg_file (
  input  logic                     clk,
  input  logic                     rst_n,
  input  dual_core_pkg::slot_t     slot0,
  input  dual_core_pkg::slot_t     slot1,
  input  dual_core_pkg::retire_t   retire0,
  input  dual_core_pkg::retire_t   retire1,
  output dual_core_pkg::operands_t operands0,
  output dual_core_pkg::operands_t operands1
);

  logic [`DC_DATA_WIDTH-1:0] regs [`DC_NUM_REGS];

  // same-cycle retires pass straight through, lane1 is the younger one
  function automatic logic [`DC_DATA_WIDTH-1:0] read_port(
    input logic [`DC_REG_ADDR_BITS-1:0] addr
  );
    if (addr == '0) begin
      return '0;
    end else if (retire1.valid && (retire1.dest == addr)) begin
      return retire1.value;
    end else if (retire0.valid && (retire0.dest == addr)) begin
      return retire0.value;
    end
    return regs[addr];
  endfunction

  ////////////////////
  // write ports

  // architectural state starts at zero
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < `DC_NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else begin
      if (retire0.valid) begin
        regs[retire0.dest] <= retire0.value;
      end
      // second write wins on equal indices
      if (retire1.valid) begin
        regs[retire1.dest] <= retire1.value;
      end
    end
  end

  ////////////////////
  // read pairs

  always_comb begin
    operands0.rs_val = read_port(slot0.inst.rs);
    operands0.rt_val = read_port(slot0.inst.rt);
    operands1.rs_val = read_port(slot1.inst.rs);
    operands1.rt_val = read_port(slot1.inst.rt);
  end

endmodule

`default_nettype wire

// ==== testbench/tb_ref_model.svh ====
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

// 32-bit xorshift, state lives in rng_state
function automatic logic [31:0] xorshift32();
  rng_state = rng_state ^ (rng_state << 13);
  rng_state = rng_state ^ (rng_state >> 17);
  rng_state = rng_state ^ (rng_state << 5);
  return rng_state;
endfunction

// r-type word, funct bits zero
function automatic logic [31:0] enc_r(input logic [5:0] op, input int rd, input int rs,
                                      input int rt, input int shamt);
  return {op, rs[4:0], rt[4:0], rd[4:0], shamt[4:0], 6'd0};
endfunction

function automatic logic [31:0] enc_addi(input int rt, input int rs, input logic [15:0] imm);
  return {6'(dual_core_pkg::OP_ADDI), rs[4:0], rt[4:0], imm};
endfunction

function automatic logic [31:0] enc_nop();
  return '0;
endfunction

// registers limited to r0..r7 so results are reused often
function automatic logic [31:0] rand_inst();
  logic [31:0] r;
  logic [5:0]  op;
  r = xorshift32();
  if (r[3:0] < 4'd9) begin
    op = {2'b00, r[3:0]};
  end else if (r[3:0] == 4'd15) begin
    // outside the instruction set
    op = 6'h2a;
  end else begin
    op = 6'(dual_core_pkg::OP_ADDI);
  end
  if (op == 6'(dual_core_pkg::OP_ADDI)) begin
    return {op, 2'b00, r[6:4], 2'b00, r[9:7], r[31:16]};
  end
  return {op, 2'b00, r[6:4], 2'b00, r[9:7], 2'b00, r[12:10], r[17:13], r[23:18]};
endfunction

// written register, zero when the instruction writes nothing
function automatic int dest_reg(input logic [31:0] inst);
  case (inst[31:26])
    dual_core_pkg::OP_ADD, dual_core_pkg::OP_SUB, dual_core_pkg::OP_AND,
    dual_core_pkg::OP_OR, dual_core_pkg::OP_XOR, dual_core_pkg::OP_SLT,
    dual_core_pkg::OP_SLL: return inst[15:11];
    dual_core_pkg::OP_ADDI: return inst[20:16];
    default: return 0;
  endcase
endfunction

// younger reads a register that older writes
function automatic logic splits(input logic [31:0] older, input logic [31:0] younger);
  int d;
  d = dest_reg(older);
  return (d != 0) && ((younger[25:21] == d) || (younger[20:16] == d));
endfunction

// in-order execution on model_regs
function automatic dual_core_pkg::retire_t ref_exec(input logic [31:0] inst);
  logic [31:0]            a;
  logic [31:0]            b;
  logic [31:0]            res;
  int                     d;
  dual_core_pkg::retire_t r;
  a = model_regs[inst[25:21]];
  b = model_regs[inst[20:16]];
  case (inst[31:26])
    dual_core_pkg::OP_ADD:  res = a + b;
    dual_core_pkg::OP_SUB:  res = a - b;
    dual_core_pkg::OP_AND:  res = a & b;
    dual_core_pkg::OP_OR:   res = a | b;
    dual_core_pkg::OP_XOR:  res = a ^ b;
    dual_core_pkg::OP_SLT:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
    dual_core_pkg::OP_SLL:  res = b << inst[10:6];
    dual_core_pkg::OP_ADDI: res = a + {16'h0000, inst[15:0]};
    default:                res = '0;
  endcase
  d = dest_reg(inst);
  r.valid = (d != 0);
  r.dest  = d[4:0];
  r.value = res;
  if (d != 0) begin
    model_regs[d] = res;
  end
  return r;
endfunction

`endif

// ==== testbench/tb_dual_core.sv ====
`default_nettype none

`include "dual_core_cfg.svh"

module tb_dual_core;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int DIRECTED_PAIRS = 17;
  localparam int RANDOM_PAIRS   = 200;
  localparam int CYCLE_LIMIT    = 2 * (DIRECTED_PAIRS + RANDOM_PAIRS) + 20;

  logic                      clk;
  logic                      rst_n;
  logic                      in_valid;
  logic                      in_ready;
  dual_core_pkg::inst_pair_t in_pair;
  dual_core_pkg::retire_t    retire0;
  dual_core_pkg::retire_t    retire1;

  // reference state
  logic [`DC_DATA_WIDTH-1:0] model_regs [`DC_NUM_REGS];
  logic [31:0]               rng_state;
  dual_core_pkg::retire_t    exp_q [$];
  logic                      split_next;
  int                        cycles = 0;

  `include "tb_ref_model.svh"

  dual_core i_dut (
    .clk      (clk),
    .rst_n    (rst_n),
    .in_valid (in_valid),
    .in_ready (in_ready),
    .in_pair  (in_pair),
    .retire0  (retire0),
    .retire1  (retire1)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  ////////////////////
  // failure reporting

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("test failed");
    $fatal(1, "stopping on the first error");
  endtask

  task automatic check(input string name, input logic [31:0] actual,
                       input logic [31:0] expected);
    if (actual !== expected) begin
      abort_run($sformatf("FAILED %s: got 0x%08h, expected 0x%08h", name, actual, expected));
    end
  endtask

  task automatic compare_retire(input string port, input dual_core_pkg::retire_t got);
    dual_core_pkg::retire_t exp;
    if (exp_q.size() == 0) begin
      abort_run($sformatf("%s retired a result that no instruction should produce", port));
    end else begin
      exp = exp_q.pop_front();
      check($sformatf("%s.dest", port), got.dest, exp.dest);
      check($sformatf("%s.value", port), got.value, exp.value);
    end
  endtask

  ////////////////////
  // stimulus

  // holds the pair until in_ready, then records expected retires
  task automatic send_pair(input logic [31:0] older, input logic [31:0] younger);
    logic                   accepted;
    dual_core_pkg::retire_t r;
    accepted = 1'b0;
    in_valid = 1'b1;
    in_pair  = {older, younger};
    while (!accepted) begin
      @(negedge clk);
      accepted = in_ready;
      @(posedge clk);
      #2;
    end
    in_valid   = 1'b0;
    split_next = splits(older, younger);
    r = ref_exec(older);
    if (r.valid) begin
      exp_q.push_back(r);
    end
    r = ref_exec(younger);
    if (r.valid) begin
      exp_q.push_back(r);
    end
  endtask

  task automatic run_directed();
    // register setup
    send_pair(enc_addi(1, 0, 16'h1234), enc_addi(2, 0, 16'hffff));
    send_pair(enc_addi(3, 0, 16'h00f0), enc_addi(4, 0, 16'h0003));
    // every opcode, reads at distance one and two pairs
    send_pair(enc_r(dual_core_pkg::OP_ADD, 5, 1, 2, 0),
              enc_r(dual_core_pkg::OP_SUB, 6, 3, 4, 0));
    send_pair(enc_r(dual_core_pkg::OP_AND, 7, 1, 2, 0),
              enc_r(dual_core_pkg::OP_OR, 8, 3, 4, 0));
    send_pair(enc_r(dual_core_pkg::OP_XOR, 9, 1, 3, 0),
              enc_r(dual_core_pkg::OP_SLT, 10, 6, 5, 0));
    send_pair(enc_r(dual_core_pkg::OP_SUB, 11, 0, 1, 0),
              enc_r(dual_core_pkg::OP_SLL, 12, 0, 2, 4));
    send_pair(enc_r(dual_core_pkg::OP_SLT, 13, 11, 1, 0),
              enc_r(dual_core_pkg::OP_SLT, 14, 1, 11, 0));
    // nothing retires from these two
    send_pair(enc_nop(), enc_r(dual_core_pkg::OP_ADD, 0, 1, 2, 0));
    send_pair(32'hfc22_7800, enc_addi(0, 1, 16'h0005));
    // younger reads older, pair splits
    send_pair(enc_addi(16, 1, 16'h0011), enc_r(dual_core_pkg::OP_ADD, 17, 16, 2, 0));
    send_pair(enc_r(dual_core_pkg::OP_SUB, 18, 17, 16, 0),
              enc_r(dual_core_pkg::OP_XOR, 19, 18, 17, 0));
    // chains across both lanes
    send_pair(enc_r(dual_core_pkg::OP_ADD, 20, 5, 6, 0),
              enc_r(dual_core_pkg::OP_ADD, 21, 7, 8, 0));
    send_pair(enc_r(dual_core_pkg::OP_ADD, 22, 20, 21, 0),
              enc_r(dual_core_pkg::OP_SUB, 23, 21, 20, 0));
    send_pair(enc_r(dual_core_pkg::OP_XOR, 24, 20, 23, 0),
              enc_r(dual_core_pkg::OP_OR, 25, 22, 21, 0));
    send_pair(enc_r(dual_core_pkg::OP_ADD, 20, 24, 25, 0),
              enc_r(dual_core_pkg::OP_SLL, 21, 0, 24, 3));
    // both write r28, the younger value must stick
    send_pair(enc_r(dual_core_pkg::OP_ADD, 28, 1, 2, 0),
              enc_r(dual_core_pkg::OP_SUB, 28, 3, 4, 0));
    send_pair(enc_addi(29, 28, 16'h0001), enc_r(dual_core_pkg::OP_OR, 30, 28, 0, 0));
  endtask

  task automatic run_random();
    logic [31:0] older;
    logic [31:0] younger;
    for (int i = 0; i < RANDOM_PAIRS; i++) begin
      older   = rand_inst();
      younger = rand_inst();
      send_pair(older, younger);
      // occasional idle cycle after a pair that issued whole
      if (!splits(older, younger) && (xorshift32() % 4 == 0)) begin
        @(posedge clk);
        #2;
      end
    end
  endtask

  initial begin
    rst_n      = 1'b0;
    in_valid   = 1'b0;
    in_pair    = '0;
    split_next = 1'b0;
    rng_state  = 32'd99;
    for (int i = 0; i < `DC_NUM_REGS; i++) begin
      model_regs[i] = '0;
    end
    repeat (3) @(posedge clk);
    #2;
    rst_n = 1'b1;
    // idle after reset, nothing may retire
    repeat (3) @(posedge clk);
    #2;
    run_directed();
    run_random();
    repeat (6) @(posedge clk);
    if (exp_q.size() != 0) begin
      abort_run($sformatf("%0d expected results never retired", exp_q.size()));
    end else begin
      $display("test passed");
      $finish;
    end
  end

  ////////////////////
  // compare

  // in_ready low only in the cycle after a splitting pair
  always @(negedge clk) begin
    if (rst_n) begin
      if ($isunknown({in_ready, retire0.valid, retire1.valid})) begin
        abort_run("in_ready or a retire valid is unknown after reset");
      end else begin
        check("in_ready", in_ready, !split_next);
        split_next = 1'b0;
        if (retire0.valid) begin
          compare_retire("retire0", retire0);
        end
        if (retire1.valid) begin
          compare_retire("retire1", retire1);
        end
      end
    end
  end

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles > CYCLE_LIMIT) begin
      abort_run($sformatf("timeout, run still going after %0d cycles", cycles));
    end
  end

endmodule

`default_nettype wire
